// File: Makefile
TOP = decodeStageTb
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f decodeStage.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^Test OK$$" $(LOG)

lint:
	verilator --lint-only --timing --assert -f decodeStage.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// File: bench/decodeStageTb.sv
`timescale 1ns/100ps

module decodeStageTb;

	localparam int halfPeriod = 20;
	localparam int resetCycles = 16;
	localparam int maxLines = 100;
	localparam string stimFile = "bench/decodeStage_stimulus.txt";

	logic clk;
	logic reset;
	isaPkg::word_t instr;
	isaPkg::word_t pc4;
	isaPkg::word_t instrW;
	isaPkg::regAddr_t a3W;
	isaPkg::word_t regDataW;
	isaPkg::word_t rd1;
	isaPkg::word_t rd2;
	isaPkg::word_t ext;
	isaPkg::word_t npc;

	int errorCount;
	int checkCount;
	int stepNum;
	int assertFails;

	decodeStage decodeStage_inst (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.pc4(pc4),
		.instrW(instrW),
		.a3W(a3W),
		.regDataW(regDataW),
		.rd1(rd1),
		.rd2(rd2),
		.ext(ext),
		.npc(npc)
	);

	bind decodeStage decodeStageProps props (
		.clk(clk),
		.reset(reset),
		.rs(dCtrl.rs),
		.rt(dCtrl.rt),
		.regWrite(wCtrl.regWrite),
		.a3W(a3W),
		.regDataW(regDataW),
		.rd1(rd1),
		.rd2(rd2),
		.npcOp(dCtrl.npcOp),
		.pc4(pc4),
		.npc(npc)
	);

	always #(halfPeriod) clk = ~clk;

	//////////////////////////////
	// Compare tasks
	//////////////////////////////
	task automatic checkWord(input string name, input isaPkg::word_t actual,
			input isaPkg::word_t expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("Mismatch %s: got %h, expected %h at step %0d", name, actual, expected,
				stepNum);
		end
	endtask

	task automatic checkNpc(input isaPkg::word_t actual, input isaPkg::word_t expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("Mismatch npc: got %h, expected %h with pc4 %h at step %0d", actual,
				expected, pc4, stepNum);
		end
	endtask

	// Drive on the falling edge and sample just before the next rising edge
	task automatic applyStep(
		input isaPkg::word_t stepInstr,
		input isaPkg::word_t stepPc4,
		input isaPkg::word_t stepInstrW,
		input isaPkg::regAddr_t stepA3W,
		input isaPkg::word_t stepData,
		input isaPkg::word_t expRd1,
		input isaPkg::word_t expRd2,
		input isaPkg::word_t expExt,
		input isaPkg::word_t expNpc
	);
		@(negedge clk);
		stepNum++;
		instr = stepInstr;
		pc4 = stepPc4;
		instrW = stepInstrW;
		a3W = stepA3W;
		regDataW = stepData;
		#(halfPeriod - 1);
		checkWord("rd1", rd1, expRd1);
		checkWord("rd2", rd2, expRd2);
		checkWord("ext", ext, expExt);
		checkNpc(npc, expNpc);
	endtask

	// Read all 32 registers in pairs with addu while write-back idles
	task automatic sweepResetValues();
		isaPkg::regAddr_t rsSel;
		isaPkg::regAddr_t rtSel;
		isaPkg::word_t sweepPc4;
		isaPkg::word_t adduInstr;
		for (int i = 0; i < 16; i++) begin
			rsSel = isaPkg::regAddr_t'(2 * i);
			rtSel = isaPkg::regAddr_t'(2 * i + 1);
			sweepPc4 = 32'h0000_1000 + isaPkg::word_t'(4 * i);
			adduInstr = {6'b000000, rsSel, rtSel, 5'd0, 5'd0, 6'b100001};
			applyStep(adduInstr, sweepPc4, 32'h0, 5'd0, 32'h0, 32'h0, 32'h0,
				32'hffff_ffff, sweepPc4 + 32'd4);
		end
	endtask

	task automatic runStimulusFile();
		int fd;
		int code;
		int fields;
		int lineCount;
		int dataLines;
		string line;
		isaPkg::word_t fInstr;
		isaPkg::word_t fPc4;
		isaPkg::word_t fInstrW;
		isaPkg::regAddr_t fA3W;
		isaPkg::word_t fData;
		isaPkg::word_t eRd1;
		isaPkg::word_t eRd2;
		isaPkg::word_t eExt;
		isaPkg::word_t eNpc;
		fd = $fopen(stimFile, "r");
		if (fd == 0) begin
			errorCount++;
			$display("Could not open the stimulus file %s", stimFile);
			return;
		end
		lineCount = 0;
		dataLines = 0;
		while (!$feof(fd) && lineCount < maxLines) begin
			lineCount++;
			code = $fgets(line, fd);
			if (code == 0 || line.len() == 0 || line[0] == "#") begin
				continue;
			end
			fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h", fInstr, fPc4, fInstrW,
				fA3W, fData, eRd1, eRd2, eExt, eNpc);
			if (fields <= 0) begin
				continue;
			end
			if (fields != 9) begin
				errorCount++;
				$display("Stimulus line %0d has %0d fields instead of 9", lineCount, fields);
				continue;
			end
			dataLines++;
			applyStep(fInstr, fPc4, fInstrW, fA3W, fData, eRd1, eRd2, eExt, eNpc);
		end
		if (!$feof(fd)) begin
			errorCount++;
			$display("End of the stimulus file not reached after %0d lines", maxLines);
		end
		if (dataLines == 0) begin
			errorCount++;
			$display("The stimulus file held no steps");
		end
		$fclose(fd);
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////
	initial begin
		clk = 1'b0;
		reset = 1'b1;
		instr = '0;
		pc4 = '0;
		instrW = '0;
		a3W = '0;
		regDataW = '0;
		errorCount = 0;
		checkCount = 0;
		stepNum = 0;
		assertFails = 0;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		sweepResetValues();
		runStimulusFile();
		assertFails = decodeStage_inst.props.failCount;
		$display("Steps %0d, checks %0d, errors %0d, assertion failures %0d", stepNum,
			checkCount, errorCount, assertFails);
		if (errorCount == 0 && assertFails == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// File: bench/decodeStage_props.sv
`timescale 1ns/100ps

module decodeStageProps (
	input logic clk,
	input logic reset,
	input isaPkg::regAddr_t rs,
	input isaPkg::regAddr_t rt,
	input logic regWrite,
	input isaPkg::regAddr_t a3W,
	input isaPkg::word_t regDataW,
	input isaPkg::word_t rd1,
	input isaPkg::word_t rd2,
	input ctrlPkg::npcOp_t npcOp,
	input isaPkg::word_t pc4,
	input isaPkg::word_t npc
);

	int failCount = 0;

	//////////////////////////////
	// Register file
	//////////////////////////////
	// Register 0 is hardwired to zero
	zeroReadRs: assert property (@(posedge clk) disable iff (reset)
		(rs == isaPkg::zeroReg) |-> (rd1 == '0))
		else begin
			failCount++;
			$error("rd1 is not zero while register 0 is read");
		end

	zeroReadRt: assert property (@(posedge clk) disable iff (reset)
		(rt == isaPkg::zeroReg) |-> (rd2 == '0))
		else begin
			failCount++;
			$error("rd2 is not zero while register 0 is read");
		end

	// A write shows up one cycle later on either read port
	writeVisibleRs: assert property (@(posedge clk) disable iff (reset)
		(regWrite && (a3W != isaPkg::zeroReg))
		|=> ((rs != $past(a3W)) || (rd1 == $past(regDataW))))
		else begin
			failCount++;
			$error("rd1 does not show the data written one cycle earlier");
		end

	writeVisibleRt: assert property (@(posedge clk) disable iff (reset)
		(regWrite && (a3W != isaPkg::zeroReg))
		|=> ((rt != $past(a3W)) || (rd2 == $past(regDataW))))
		else begin
			failCount++;
			$error("rd2 does not show the data written one cycle earlier");
		end

	//////////////////////////////
	// Next PC
	//////////////////////////////
	seqNpc: assert property (@(posedge clk) disable iff (reset)
		(npcOp == ctrlPkg::npcSeq) |-> (npc == pc4 + 32'd4))
		else begin
			failCount++;
			$error("Sequential next PC is not pc4 plus 4");
		end

endmodule

// File: bench/decodeStage_stimulus.txt
# instr    pc4      instrW   a3W regDataW expRd1   expRd2   expExt   expNpc
# expected outputs hold just before the rising edge that performs the write-back
00000000 00003004 00000021 01 11111111 00000000 00000000 ffffffff 00003008
00221821 00003008 3c000000 02 22220000 11111111 00000000 ffffffff 0000300c
00221821 0000300c 0c000000 1f 00003010 11111111 22220000 ffffffff 00003010
03e00008 00003010 ac000000 03 deadbeef 00003010 00000000 ffffffff 00003010
00630021 00003014 10000000 04 12345678 00000000 00000000 ffffffff 00003018
00800021 00003018 00000021 00 cafef00d 00000000 00000000 ffffffff 0000301c
00000021 0000301c 00000000 00 00000000 00000000 00000000 ffffffff 00003020
34258001 00003020 34000000 05 0000ffff 11111111 00000000 00008001 00003024
8c45fffc 00003024 8c000000 06 22220000 22220000 0000ffff fffffffc 00003028
ac067ff0 00003028 00000000 00 00000000 00000000 22220000 00007ff0 0000302c
3c07abcd 0000302c 00000023 07 0000ff00 00000000 00000000 abcd0000 00003030
10460010 00003030 00000000 00 00000000 22220000 22220000 ffffffff 00003070
10c2fff8 00003034 00000000 00 00000000 22220000 22220000 ffffffff 00003014
10220010 00003038 00000000 00 00000000 11111111 22220000 ffffffff 0000303c
08100040 20000000 00000000 00 00000000 00000000 00000000 ffffffff 10400100
0c000c00 90000004 00000000 00 00000000 00000000 00000000 ffffffff 90003000
00200008 00003040 00000000 00 00000000 11111111 00000000 ffffffff 11111111
00e54023 00003044 00000000 00 00000000 0000ff00 0000ffff ffffffff 00003048
37e41234 00003048 00000000 00 00000000 00003010 00000000 00001234 0000304c
00000000 fffffffc 00000000 00 00000000 00000000 00000000 ffffffff 00000000

// File: decodeStage.f
rtl/isaPkg.sv
rtl/ctrlPkg.sv
rtl/decodeCtrlIf.sv
rtl/instrDecoder.sv
rtl/regFile.sv
rtl/immExtender.sv
rtl/nextPcUnit.sv
rtl/decodeStage.sv
bench/decodeStage_props.sv
bench/decodeStageTb.sv

// File: rtl/ctrlPkg.sv
package ctrlPkg;

	//////////////////////////////
	// Immediate extension
	//////////////////////////////
	typedef logic [1:0] extOp_t;

	localparam extOp_t extZero = 2'd0;
	localparam extOp_t extSign = 2'd1;
	localparam extOp_t extUpper = 2'd2;
	// Instructions without an immediate, output is all ones
	localparam extOp_t extNone = 2'd3;

	//////////////////////////////
	// Next-PC selection
	//////////////////////////////
	typedef logic [1:0] npcOp_t;

	// pc4 + 4, past the delay slot
	localparam npcOp_t npcSeq = 2'd0;
	localparam npcOp_t npcBranch = 2'd1;
	localparam npcOp_t npcJump = 2'd2;
	// Target taken from rs
	localparam npcOp_t npcReg = 2'd3;

endpackage

// File: rtl/decodeCtrlIf.sv
`timescale 1ns/100ps

interface decodeCtrlIf;

	isaPkg::regAddr_t rs;
	isaPkg::regAddr_t rt;
	isaPkg::imm16_t imm16;
	isaPkg::target26_t target26;
	ctrlPkg::extOp_t extOp;
	ctrlPkg::npcOp_t npcOp;
	logic regWrite;

	modport decoder (output rs, rt, imm16, target26, extOp, npcOp, regWrite);

	modport regRead (input rs, rt);

	modport writeBack (input regWrite);

	modport extend (input extOp, imm16);

	modport npcSel (input npcOp, imm16, target26);

endinterface

// File: rtl/decodeStage.sv
`timescale 1ns/100ps

module decodeStage (
	input logic clk,
	input logic reset,
	input isaPkg::word_t instr,
	input isaPkg::word_t pc4,
	input isaPkg::word_t instrW,
	input isaPkg::regAddr_t a3W,
	input isaPkg::word_t regDataW,
	output isaPkg::word_t rd1,
	output isaPkg::word_t rd2,
	output isaPkg::word_t ext,
	output isaPkg::word_t npc
);

	//////////////////////////////
	// Decoded control
	//////////////////////////////
	// Instruction in decode
	decodeCtrlIf dCtrl ();
	// Instruction in write-back
	decodeCtrlIf wCtrl ();

	instrDecoder decInst (
		.instr(instr),
		.ctrl(dCtrl.decoder)
	);

	// Only regWrite of this copy is consumed
	instrDecoder decWb (
		.instr(instrW),
		.ctrl(wCtrl.decoder)
	);

	//////////////////////////////
	// Datapath
	//////////////////////////////
	regFile regs (
		.clk(clk),
		.reset(reset),
		.rdCtrl(dCtrl.regRead),
		.wbCtrl(wCtrl.writeBack),
		.a3W(a3W),
		.regDataW(regDataW),
		.rd1(rd1),
		.rd2(rd2)
	);

	immExtender extUnit (
		.ctrl(dCtrl.extend),
		.ext(ext)
	);

	// Compares the raw register reads, no forwarding here
	nextPcUnit npcUnit (
		.pc4(pc4),
		.ctrl(dCtrl.npcSel),
		.rd1(rd1),
		.rd2(rd2),
		.npc(npc)
	);

endmodule

// File: rtl/immExtender.sv
`timescale 1ns/100ps

module immExtender (
	decodeCtrlIf.extend ctrl,
	output isaPkg::word_t ext
);

	always_comb begin
		case (ctrl.extOp)
			ctrlPkg::extZero: begin
				ext = {16'b0, ctrl.imm16};
			end
			ctrlPkg::extSign: begin
				ext = {{16{ctrl.imm16[15]}}, ctrl.imm16};
			end
			// lui loads the upper half
			ctrlPkg::extUpper: begin
				ext = {ctrl.imm16, 16'b0};
			end
			default: begin
				ext = '1;
			end
		endcase
	end

endmodule

// File: rtl/instrDecoder.sv
`timescale 1ns/100ps

module instrDecoder (
	input isaPkg::word_t instr,
	decodeCtrlIf.decoder ctrl
);

	isaPkg::opcode_t opcode;
	isaPkg::funct_t funct;
	logic isRtype;
	logic isAddu;
	logic isSubu;
	logic isJr;
	logic isOri;
	logic isLw;
	logic isSw;
	logic isBeq;
	logic isLui;
	logic isJ;
	logic isJal;

	//////////////////////////////
	// Field slicing
	//////////////////////////////
	assign opcode = instr[31:26];
	assign funct = instr[5:0];

	assign ctrl.rs = instr[25:21];
	assign ctrl.rt = instr[20:16];
	assign ctrl.imm16 = instr[15:0];
	assign ctrl.target26 = instr[25:0];

	//////////////////////////////
	// Instruction match
	//////////////////////////////
	assign isRtype = (opcode == isaPkg::opRtype);
	assign isAddu = isRtype && (funct == isaPkg::functAddu);
	assign isSubu = isRtype && (funct == isaPkg::functSubu);
	assign isJr = isRtype && (funct == isaPkg::functJr);
	assign isOri = (opcode == isaPkg::opOri);
	assign isLw = (opcode == isaPkg::opLw);
	assign isSw = (opcode == isaPkg::opSw);
	assign isBeq = (opcode == isaPkg::opBeq);
	assign isLui = (opcode == isaPkg::opLui);
	assign isJ = (opcode == isaPkg::opJ);
	assign isJal = (opcode == isaPkg::opJal);

	// Extension select
	always_comb begin
		if (isOri) begin
			ctrl.extOp = ctrlPkg::extZero;
		end else if (isLw || isSw) begin
			ctrl.extOp = ctrlPkg::extSign;
		end else if (isLui) begin
			ctrl.extOp = ctrlPkg::extUpper;
		end else begin
			ctrl.extOp = ctrlPkg::extNone;
		end
	end

	// Next-PC select, nop and unknown codes fall through to sequential
	always_comb begin
		if (isBeq) begin
			ctrl.npcOp = ctrlPkg::npcBranch;
		end else if (isJ || isJal) begin
			ctrl.npcOp = ctrlPkg::npcJump;
		end else if (isJr) begin
			ctrl.npcOp = ctrlPkg::npcReg;
		end else begin
			ctrl.npcOp = ctrlPkg::npcSeq;
		end
	end

	// Instructions that produce a register result
	assign ctrl.regWrite = isAddu || isSubu || isOri || isLw || isLui || isJal;

endmodule

// File: rtl/isaPkg.sv
package isaPkg;

	//////////////////////////////
	// Field widths
	//////////////////////////////
	localparam int wordWidth = 32;
	localparam int regAddrWidth = 5;
	localparam int opcodeWidth = 6;
	localparam int functWidth = 6;
	localparam int immWidth = 16;
	localparam int targetWidth = 26;
	localparam int regCount = 1 << regAddrWidth;

	typedef logic [wordWidth-1:0] word_t;
	typedef logic [regAddrWidth-1:0] regAddr_t;
	typedef logic [opcodeWidth-1:0] opcode_t;
	typedef logic [functWidth-1:0] funct_t;
	typedef logic [immWidth-1:0] imm16_t;
	typedef logic [targetWidth-1:0] target26_t;

	//////////////////////////////
	// Primary opcodes
	//////////////////////////////
	// Special group, decoded further by funct
	localparam opcode_t opRtype = 6'b000000;
	localparam opcode_t opOri = 6'b001101;
	localparam opcode_t opLw = 6'b100011;
	localparam opcode_t opSw = 6'b101011;
	localparam opcode_t opBeq = 6'b000100;
	localparam opcode_t opLui = 6'b001111;
	localparam opcode_t opJ = 6'b000010;
	localparam opcode_t opJal = 6'b000011;

	// Funct codes within the special group
	localparam funct_t functAddu = 6'b100001;
	localparam funct_t functSubu = 6'b100011;
	localparam funct_t functJr = 6'b001000;

	// Named registers
	localparam regAddr_t zeroReg = 5'd0;
	localparam regAddr_t linkReg = 5'd31;

	// Boot address of the fetch stage
	localparam word_t resetPc = 32'h0000_3000;

endpackage

// File: rtl/nextPcUnit.sv
`timescale 1ns/100ps

module nextPcUnit (
	input isaPkg::word_t pc4,
	decodeCtrlIf.npcSel ctrl,
	input isaPkg::word_t rd1,
	input isaPkg::word_t rd2,
	output isaPkg::word_t npc
);

	isaPkg::word_t pc;
	isaPkg::word_t branchOffset;
	isaPkg::word_t seqPc;
	logic regsEqual;

	//////////////////////////////
	// Operand prep
	//////////////////////////////
	// PC of the instruction in decode
	assign pc = pc4 - 32'd4;

	// Word offset scaled to bytes
	assign branchOffset = {{14{ctrl.imm16[15]}}, ctrl.imm16, 2'b00};

	// Skip the delay slot
	assign seqPc = pc4 + 32'd4;

	// beq comparator
	assign regsEqual = (rd1 == rd2);

	//////////////////////////////
	// Target select
	//////////////////////////////
	always_comb begin
		case (ctrl.npcOp)
			ctrlPkg::npcBranch: begin
				if (regsEqual) begin
					npc = pc4 + branchOffset;
				end else begin
					npc = seqPc;
				end
			end
			// Region bits come from the jump's own PC
			ctrlPkg::npcJump: begin
				npc = {pc[31:28], ctrl.target26, 2'b00};
			end
			ctrlPkg::npcReg: begin
				npc = rd1;
			end
			default: begin
				npc = seqPc;
			end
		endcase
	end

endmodule

// File: rtl/regFile.sv
`timescale 1ns/100ps

module regFile (
	input logic clk,
	input logic reset,
	decodeCtrlIf.regRead rdCtrl,
	decodeCtrlIf.writeBack wbCtrl,
	input isaPkg::regAddr_t a3W,
	input isaPkg::word_t regDataW,
	output isaPkg::word_t rd1,
	output isaPkg::word_t rd2
);

	isaPkg::word_t regs [isaPkg::regCount];

	//////////////////////////////
	// Read ports
	//////////////////////////////
	// No bypass from write-back, a write shows up after the edge
	assign rd1 = regs[rdCtrl.rs];
	assign rd2 = regs[rdCtrl.rt];

	//////////////////////////////
	// Write port
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < isaPkg::regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (wbCtrl.regWrite && (a3W != isaPkg::zeroReg)) begin
			// Register 0 is hardwired, writes to it are dropped
			regs[a3W] <= regDataW;
		end
	end

endmodule
